/* list.f */
+incdir+rtl
rtl/csr_pkg.sv
rtl/csr_counter64.sv
rtl/csr_timer.sv
rtl/csr_trap_regs.sv
rtl/csr_file.sv
verif/csr_file_tb.sv

/* rtl/csr_counter64.sv */
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_counter64 #(
    parameter csr_pkg::csr_addr_t ADDR_LO  = `CSR_ADDR_MCYCLE,
    parameter csr_pkg::csr_addr_t ADDR_HI  = `CSR_ADDR_MCYCLEH,
    parameter csr_pkg::csr_addr_t ALIAS_LO = `CSR_ADDR_CYCLE,
    parameter csr_pkg::csr_addr_t ALIAS_HI = `CSR_ADDR_CYCLEH
) (
    input  logic                Clk,
    input  logic                reset,
    input  logic                inc,
    input  logic                csr_wren,
    input  csr_pkg::csr_op_t    csr_op,
    input  csr_pkg::csr_addr_t  csr_addr,
    input  csr_pkg::csr_word_t  wdata,
    output csr_pkg::csr_word_t  read_data
);
    import csr_pkg::*;

    csr_word_t cnt_lo;
    csr_word_t cnt_hi;
    csr_word_t next_lo;
    csr_word_t next_hi;
    logic      carry;

    // ==============================
    // Next value
    // ==============================
    always_comb begin
        // Hardware increment with carry into the upper half
        {carry, next_lo} = {1'b0, cnt_lo} + {{`CSR_XLEN{1'b0}}, inc};
        next_hi          = cnt_hi + csr_word_t'(carry);
        // Software access replaces the hardware value of that half
        if (csr_wren && (csr_addr == ADDR_LO)) begin
            next_lo = csr_modify(cnt_lo, wdata, csr_op);
        end
        if (csr_wren && (csr_addr == ADDR_HI)) begin
            next_hi = csr_modify(cnt_hi, wdata, csr_op);
        end
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            cnt_lo <= '0;
            cnt_hi <= '0;
        end else begin
            cnt_lo <= next_lo;
            cnt_hi <= next_hi;
        end
    end

    // Both the machine address and the user alias read the same half
    always_comb begin
        case (csr_addr)
            ADDR_LO, ALIAS_LO: read_data = cnt_lo;
            ADDR_HI, ALIAS_HI: read_data = cnt_hi;
            default:           read_data = '0;
        endcase
    end

endmodule

/* rtl/csr_file.sv */
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_file (
    input  logic                Clk,
    input  logic                reset,
    input  logic                csr_wren,
    input  logic                csr_rden,
    input  csr_pkg::csr_op_t    csr_op,
    input  csr_pkg::csr_addr_t  csr_addr,
    input  logic                csr_imm_bit,
    input  csr_pkg::csr_word_t  csr_imm,
    input  csr_pkg::csr_word_t  csr_wdata,
    input  logic                inst_retired,
    input  logic                illegal_instruction,
    input  logic                misaligned_access,
    input  logic                illegal_csr_access,
    input  logic                breakpoint,
    input  logic                external_interrupt,
    input  logic                timer_interrupt_taken,
    input  logic                mret,
    input  csr_pkg::csr_word_t  trap_pc,
    input  csr_pkg::csr_word_t  trap_mtval,
    output csr_pkg::csr_word_t  read_data,
    output logic                jump_en,
    output csr_pkg::csr_word_t  jump_addr,
    output logic                return_en,
    output csr_pkg::csr_word_t  return_addr,
    output logic                timer_irq_en
);
    import csr_pkg::*;

    csr_word_t csr_src;
    csr_word_t rd_mcycle, rd_minstret, rd_timer, rd_trap;
    logic      cycle_inc;
    logic      timer_pending;

    // Immediate form of the instruction replaces rs1
    assign csr_src = csr_imm_bit ? csr_imm : csr_wdata;

    // mcycle counts whenever the core is out of reset
    assign cycle_inc = ~reset;

    // ==============================
    // Register blocks
    // ==============================
    csr_counter64 #(
        .ADDR_LO  (`CSR_ADDR_MCYCLE),
        .ADDR_HI  (`CSR_ADDR_MCYCLEH),
        .ALIAS_LO (`CSR_ADDR_CYCLE),
        .ALIAS_HI (`CSR_ADDR_CYCLEH)
    ) i_mcycle (
        .Clk(Clk), .reset(reset), .inc(cycle_inc),
        .csr_wren(csr_wren), .csr_op(csr_op), .csr_addr(csr_addr),
        .wdata(csr_src), .read_data(rd_mcycle)
    );

    csr_counter64 #(
        .ADDR_LO  (`CSR_ADDR_MINSTRET),
        .ADDR_HI  (`CSR_ADDR_MINSTRETH),
        .ALIAS_LO (`CSR_ADDR_INSTRET),
        .ALIAS_HI (`CSR_ADDR_INSTRETH)
    ) i_minstret (
        .Clk(Clk), .reset(reset), .inc(inst_retired),
        .csr_wren(csr_wren), .csr_op(csr_op), .csr_addr(csr_addr),
        .wdata(csr_src), .read_data(rd_minstret)
    );

    csr_timer i_timer (
        .Clk(Clk), .reset(reset),
        .csr_wren(csr_wren), .csr_op(csr_op), .csr_addr(csr_addr),
        .wdata(csr_src), .read_data(rd_timer), .timer_pending(timer_pending)
    );

    csr_trap_regs i_trap (
        .Clk(Clk), .reset(reset),
        .csr_wren(csr_wren), .csr_op(csr_op), .csr_addr(csr_addr), .wdata(csr_src),
        .illegal_instruction(illegal_instruction), .misaligned_access(misaligned_access),
        .illegal_csr_access(illegal_csr_access), .breakpoint(breakpoint),
        .external_interrupt(external_interrupt),
        .timer_interrupt_taken(timer_interrupt_taken), .mret(mret),
        .trap_pc(trap_pc), .trap_mtval(trap_mtval), .timer_pending(timer_pending),
        .read_data(rd_trap), .jump_en(jump_en), .jump_addr(jump_addr),
        .return_en(return_en), .return_addr(return_addr), .timer_irq_en(timer_irq_en)
    );

    // Each block returns zero outside its own addresses
    assign read_data = csr_rden ? (rd_mcycle | rd_minstret | rd_timer | rd_trap) : '0;

endmodule

/* rtl/csr_pkg.sv */
`include "csr_settings.svh"

package csr_pkg;

    // ==============================
    // Shared types
    // ==============================
    typedef logic [`CSR_XLEN-1:0]   csr_word_t;
    typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;

    // Encoding follows the funct3 low bits of the CSR instructions
    typedef enum logic [1:0] {
        CSR_OP_NONE  = 2'd0,
        CSR_OP_WRITE = 2'd1,
        CSR_OP_SET   = 2'd2,
        CSR_OP_CLEAR = 2'd3
    } csr_op_t;

    // ==============================
    // Read-modify-write of one CSR word
    // ==============================
    function automatic csr_word_t csr_modify(
        input csr_word_t old_value,
        input csr_word_t src,
        input csr_op_t   op
    );
        csr_word_t result;
        case (op)
            CSR_OP_WRITE: begin
                result = src;
            end
            CSR_OP_SET: begin
                result = old_value | src;
            end
            CSR_OP_CLEAR: begin
                result = old_value & ~src;
            end
            // No op keeps the register as it is
            default: begin
                result = old_value;
            end
        endcase
        return result;
    endfunction

endpackage

/* rtl/csr_settings.svh */
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

// ==============================
// Widths
// ==============================
`define CSR_XLEN    32
`define CSR_ADDR_W  12

// ==============================
// CSR addresses
// ==============================
`define CSR_ADDR_MSTATUS         12'h300
`define CSR_ADDR_MIE             12'h304
`define CSR_ADDR_MTVEC           12'h305
`define CSR_ADDR_MSCRATCH        12'h340
`define CSR_ADDR_MEPC            12'h341
`define CSR_ADDR_MCAUSE          12'h342
`define CSR_ADDR_MTVAL           12'h343
`define CSR_ADDR_MIP             12'h344
`define CSR_ADDR_MCYCLE          12'hB00
`define CSR_ADDR_MINSTRET        12'hB02
`define CSR_ADDR_MCYCLEH         12'hB80
`define CSR_ADDR_MINSTRETH       12'hB82
// User-level read-only aliases
`define CSR_ADDR_CYCLE           12'hC00
`define CSR_ADDR_INSTRET         12'hC02
`define CSR_ADDR_CYCLEH          12'hC80
`define CSR_ADDR_INSTRETH        12'hC82
// Custom machine timer
`define CSR_ADDR_CUSTOM_MTIME    12'hBC0
`define CSR_ADDR_CUSTOM_MTIMECMP 12'hBC1

// ==============================
// Trap causes and register images
// ==============================
`define CAUSE_ILLEGAL_INSTR  32'h00000002
`define CAUSE_BREAKPOINT     32'h00000003
`define CAUSE_MISALIGNED     32'h00000004
`define CAUSE_ILLEGAL_CSR    32'h0000000B
`define CAUSE_TIMER          32'h80000007
`define MSTATUS_ON_TRAP      32'h00000080
`define MSTATUS_ON_MRET      32'h00000008
`define MIE_ON_TRAP          32'h00000808
`define MIE_ON_MRET          32'h00000888
`define MIP_TIMER_PENDING    32'h00000080
`define MSTATUS_MIE_BIT      3
`define MIE_MTIE_BIT         7

`endif

/* rtl/csr_timer.sv */
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_timer (
    input  logic                Clk,
    input  logic                reset,
    input  logic                csr_wren,
    input  csr_pkg::csr_op_t    csr_op,
    input  csr_pkg::csr_addr_t  csr_addr,
    input  csr_pkg::csr_word_t  wdata,
    output csr_pkg::csr_word_t  read_data,
    output logic                timer_pending
);
    import csr_pkg::*;

    csr_word_t mtime;
    csr_word_t mtimecmp;

    // ==============================
    // Timer registers
    // ==============================
    // mtime is free running and ignores software writes
    always_ff @(posedge Clk) begin
        if (reset) begin
            mtime    <= '0;
            mtimecmp <= '0;
        end else begin
            mtime <= mtime + csr_word_t'(1);
            if (csr_wren && (csr_addr == `CSR_ADDR_CUSTOM_MTIMECMP)) begin
                mtimecmp <= csr_modify(mtimecmp, wdata, csr_op);
            end
        end
    end

    // A zero compare value keeps the timer disarmed
    assign timer_pending = (mtime >= mtimecmp) && (mtimecmp != '0);

    // Read port
    always_comb begin
        case (csr_addr)
            `CSR_ADDR_CUSTOM_MTIME:    read_data = mtime;
            `CSR_ADDR_CUSTOM_MTIMECMP: read_data = mtimecmp;
            default:                   read_data = '0;
        endcase
    end

endmodule

/* rtl/csr_trap_regs.sv */
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_trap_regs (
    input  logic                Clk,
    input  logic                reset,
    input  logic                csr_wren,
    input  csr_pkg::csr_op_t    csr_op,
    input  csr_pkg::csr_addr_t  csr_addr,
    input  csr_pkg::csr_word_t  wdata,
    input  logic                illegal_instruction,
    input  logic                misaligned_access,
    input  logic                illegal_csr_access,
    input  logic                breakpoint,
    input  logic                external_interrupt,
    input  logic                timer_interrupt_taken,
    input  logic                mret,
    input  csr_pkg::csr_word_t  trap_pc,
    input  csr_pkg::csr_word_t  trap_mtval,
    input  logic                timer_pending,
    output csr_pkg::csr_word_t  read_data,
    output logic                jump_en,
    output csr_pkg::csr_word_t  jump_addr,
    output logic                return_en,
    output csr_pkg::csr_word_t  return_addr,
    output logic                timer_irq_en
);
    import csr_pkg::*;

    csr_word_t mstatus, mie, mip, mtvec, mscratch, mepc, mcause, mtval;
    csr_word_t mstatus_nxt, mie_nxt, mip_nxt, mtvec_nxt;
    csr_word_t mscratch_nxt, mepc_nxt, mcause_nxt, mtval_nxt;

    // ==============================
    // Next state
    // ==============================
    always_comb begin
        mstatus_nxt  = mstatus;
        mie_nxt      = mie;
        mip_nxt      = mip;
        mtvec_nxt    = mtvec;
        mscratch_nxt = mscratch;
        mepc_nxt     = mepc;
        mcause_nxt   = mcause;
        mtval_nxt    = mtval;

        if (timer_pending) begin
            mip_nxt = `MIP_TIMER_PENDING;
        end

        // Later synchronous exception checks take priority
        if (illegal_instruction) begin
            mcause_nxt = `CAUSE_ILLEGAL_INSTR;
            mepc_nxt   = trap_pc;
            mtval_nxt  = trap_mtval;
        end
        if (misaligned_access) begin
            mcause_nxt = `CAUSE_MISALIGNED;
            mepc_nxt   = trap_pc;
            mtval_nxt  = trap_mtval;
        end
        if (illegal_csr_access) begin
            mcause_nxt = `CAUSE_ILLEGAL_CSR;
            mepc_nxt   = trap_pc;
            mtval_nxt  = trap_mtval;
        end
        if (breakpoint) begin
            mcause_nxt = `CAUSE_BREAKPOINT;
            mepc_nxt   = trap_pc;
            mtval_nxt  = trap_mtval;
        end

        // Timer entry masks further interrupts
        if (timer_interrupt_taken) begin
            mcause_nxt  = `CAUSE_TIMER;
            mepc_nxt    = trap_pc;
            mie_nxt     = `MIE_ON_TRAP;
            mstatus_nxt = `MSTATUS_ON_TRAP;
        end

        if (mret) begin
            mie_nxt     = `MIE_ON_MRET;
            mstatus_nxt = `MSTATUS_ON_MRET;
            mip_nxt     = '0;
        end

        // Software access has the last word
        if (csr_wren) begin
            case (csr_addr)
                `CSR_ADDR_MSTATUS:  mstatus_nxt  = csr_modify(mstatus, wdata, csr_op);
                `CSR_ADDR_MIE:      mie_nxt      = csr_modify(mie, wdata, csr_op);
                `CSR_ADDR_MIP:      mip_nxt      = csr_modify(mip, wdata, csr_op);
                `CSR_ADDR_MTVEC:    mtvec_nxt    = csr_modify(mtvec, wdata, csr_op);
                `CSR_ADDR_MSCRATCH: mscratch_nxt = csr_modify(mscratch, wdata, csr_op);
                `CSR_ADDR_MEPC:     mepc_nxt     = csr_modify(mepc, wdata, csr_op);
                `CSR_ADDR_MCAUSE:   mcause_nxt   = csr_modify(mcause, wdata, csr_op);
                `CSR_ADDR_MTVAL:    mtval_nxt    = csr_modify(mtval, wdata, csr_op);
                default: ;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            mstatus  <= '0;
            mie      <= '0;
            mip      <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
        end else begin
            mstatus  <= mstatus_nxt;
            mie      <= mie_nxt;
            mip      <= mip_nxt;
            mtvec    <= mtvec_nxt;
            mscratch <= mscratch_nxt;
            mepc     <= mepc_nxt;
            mcause   <= mcause_nxt;
            mtval    <= mtval_nxt;
        end
    end

    // Read port
    always_comb begin
        case (csr_addr)
            `CSR_ADDR_MSTATUS:  read_data = mstatus;
            `CSR_ADDR_MIE:      read_data = mie;
            `CSR_ADDR_MIP:      read_data = mip;
            `CSR_ADDR_MTVEC:    read_data = mtvec;
            `CSR_ADDR_MSCRATCH: read_data = mscratch;
            `CSR_ADDR_MEPC:     read_data = mepc;
            `CSR_ADDR_MCAUSE:   read_data = mcause;
            `CSR_ADDR_MTVAL:    read_data = mtval;
            default:            read_data = '0;
        endcase
    end

    // ==============================
    // PC redirect to the core
    // ==============================
    assign jump_en = illegal_instruction | misaligned_access | illegal_csr_access |
                     breakpoint | external_interrupt | timer_interrupt_taken;
    assign jump_addr   = mtvec;
    assign return_en   = mret;
    assign return_addr = mepc;

    // Dropped in the cycle the core takes the interrupt
    assign timer_irq_en = timer_pending & mstatus[`MSTATUS_MIE_BIT] &
                          mie[`MIE_MTIE_BIT] & ~timer_interrupt_taken;

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 -f list.f --top-module csr_file_tb -o csr_file_tb_sim

output=$(./obj_dir/csr_file_tb_sim)
echo "$output"

if echo "$output" | grep -qx "Test OK"; then
    exit 0
fi
exit 1

/* verif/csr_file_tb.sv */
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_file_tb;
    import csr_pkg::*;

    localparam int ACT_ACCESS   = 0;
    localparam int ACT_TRAP     = 1;
    localparam int ACT_MRET     = 2;
    localparam int ACT_RETIRE   = 3;
    localparam int ACT_WAIT_IRQ = 4;

    localparam int CHK_NONE  = 0;
    localparam int CHK_VALUE = 1;
    localparam int CHK_MODEL = 2;

    // Flag bits from high to low are timer taken, external, breakpoint,
    // illegal CSR, misaligned and illegal instruction
    localparam logic [5:0] FLAG_ILLEGAL_CSR = 6'b000100;
    localparam logic [5:0] FLAG_BREAKPOINT  = 6'b001000;
    localparam logic [5:0] FLAG_EXTERNAL    = 6'b010000;
    localparam logic [5:0] FLAG_TIMER_TAKEN = 6'b100000;

    localparam int IRQ_TIMEOUT = 400;

    typedef struct {
        int         act;
        logic [5:0] flags;
        csr_op_t    op;
        csr_addr_t  addr;
        logic       imm;
        csr_word_t  data;
        csr_word_t  mtval;
        logic       rden;
        int         chk;
        csr_word_t  exp;
        logic       exp_jump;
        logic       exp_ret;
        csr_word_t  exp_addr;
    } row_t;

    logic      clk;
    logic      reset;
    logic      csr_wren;
    logic      csr_rden;
    csr_op_t   csr_op;
    csr_addr_t csr_addr;
    logic      csr_imm_bit;
    csr_word_t csr_imm;
    csr_word_t csr_wdata;
    logic      inst_retired;
    logic      illegal_instruction;
    logic      misaligned_access;
    logic      illegal_csr_access;
    logic      breakpoint;
    logic      external_interrupt;
    logic      timer_interrupt_taken;
    logic      mret;
    csr_word_t trap_pc;
    csr_word_t trap_mtval;
    csr_word_t read_data;
    logic      jump_en;
    csr_word_t jump_addr;
    logic      return_en;
    csr_word_t return_addr;
    logic      timer_irq_en;

    logic [63:0] cycle_model;
    logic [63:0] retire_model;
    csr_word_t   mtime_model;
    int          errors;
    int          rows_done;
    row_t        rows[$];

    csr_file i_dut (
        .Clk(clk), .reset(reset), .csr_wren(csr_wren), .csr_rden(csr_rden),
        .csr_op(csr_op), .csr_addr(csr_addr), .csr_imm_bit(csr_imm_bit),
        .csr_imm(csr_imm), .csr_wdata(csr_wdata), .inst_retired(inst_retired),
        .illegal_instruction(illegal_instruction), .misaligned_access(misaligned_access),
        .illegal_csr_access(illegal_csr_access), .breakpoint(breakpoint),
        .external_interrupt(external_interrupt),
        .timer_interrupt_taken(timer_interrupt_taken), .mret(mret),
        .trap_pc(trap_pc), .trap_mtval(trap_mtval), .read_data(read_data),
        .jump_en(jump_en), .jump_addr(jump_addr), .return_en(return_en),
        .return_addr(return_addr), .timer_irq_en(timer_irq_en)
    );

    always #10 clk = ~clk;

    // ==============================
    // Counter models
    // ==============================
    always @(posedge clk) begin
        if (reset) begin
            cycle_model  <= '0;
            retire_model <= '0;
            mtime_model  <= '0;
        end else begin
            // Only plain writes to mcycle appear in the table
            if (csr_wren && csr_addr == `CSR_ADDR_MCYCLE && csr_op == CSR_OP_WRITE) begin
                cycle_model <= {cycle_model[63:32], (csr_imm_bit ? csr_imm : csr_wdata)};
            end else begin
                cycle_model <= cycle_model + 64'd1;
            end
            if (inst_retired) begin
                retire_model <= retire_model + 64'd1;
            end
            mtime_model <= mtime_model + 32'd1;
        end
    end

    function automatic csr_word_t model_read(input csr_addr_t addr);
        csr_word_t value;
        case (addr)
            `CSR_ADDR_MCYCLE, `CSR_ADDR_CYCLE:       value = cycle_model[31:0];
            `CSR_ADDR_MCYCLEH, `CSR_ADDR_CYCLEH:     value = cycle_model[63:32];
            `CSR_ADDR_MINSTRET, `CSR_ADDR_INSTRET:   value = retire_model[31:0];
            `CSR_ADDR_MINSTRETH, `CSR_ADDR_INSTRETH: value = retire_model[63:32];
            `CSR_ADDR_CUSTOM_MTIME:                  value = mtime_model;
            default:                                 value = '0;
        endcase
        return value;
    endfunction

    // ==============================
    // Table rows
    // ==============================
    function automatic row_t idle_row();
        row_t r;
        r.act      = ACT_ACCESS;
        r.flags    = '0;
        r.op       = CSR_OP_NONE;
        r.addr     = '0;
        r.imm      = 1'b0;
        r.data     = '0;
        r.mtval    = '0;
        r.rden     = 1'b0;
        r.chk      = CHK_NONE;
        r.exp      = '0;
        r.exp_jump = 1'b0;
        r.exp_ret  = 1'b0;
        r.exp_addr = '0;
        return r;
    endfunction

    task automatic write_row(input csr_op_t op, input csr_addr_t addr, input logic imm,
                             input csr_word_t data);
        row_t r;
        r      = idle_row();
        r.op   = op;
        r.addr = addr;
        r.imm  = imm;
        r.data = data;
        rows.push_back(r);
    endtask

    task automatic read_row(input csr_addr_t addr, input csr_word_t expected);
        row_t r;
        r      = idle_row();
        r.addr = addr;
        r.rden = 1'b1;
        r.chk  = CHK_VALUE;
        r.exp  = expected;
        rows.push_back(r);
    endtask

    task automatic model_row(input csr_addr_t addr);
        row_t r;
        r      = idle_row();
        r.addr = addr;
        r.rden = 1'b1;
        r.chk  = CHK_MODEL;
        rows.push_back(r);
    endtask

    // rden low must hide the register
    task automatic masked_read_row(input csr_addr_t addr);
        row_t r;
        r      = idle_row();
        r.addr = addr;
        r.chk  = CHK_VALUE;
        rows.push_back(r);
    endtask

    task automatic trap_row(input logic [5:0] flags, input csr_word_t pc,
                            input csr_word_t mtval, input csr_word_t target);
        row_t r;
        r          = idle_row();
        r.act      = ACT_TRAP;
        r.flags    = flags;
        r.data     = pc;
        r.mtval    = mtval;
        r.exp_jump = 1'b1;
        r.exp_addr = target;
        rows.push_back(r);
    endtask

    task automatic mret_row(input csr_word_t target);
        row_t r;
        r          = idle_row();
        r.act      = ACT_MRET;
        r.exp_ret  = 1'b1;
        r.exp_addr = target;
        rows.push_back(r);
    endtask

    task automatic retire_row();
        row_t r;
        r     = idle_row();
        r.act = ACT_RETIRE;
        rows.push_back(r);
    endtask

    task automatic irq_row(input csr_word_t rise_time);
        row_t r;
        r      = idle_row();
        r.act  = ACT_WAIT_IRQ;
        r.data = rise_time;
        rows.push_back(r);
    endtask

    task automatic build_table();
        // mscratch read-modify-write through both sources
        write_row(CSR_OP_WRITE, `CSR_ADDR_MSCRATCH, 1'b0, 32'h12345678);
        read_row(`CSR_ADDR_MSCRATCH, 32'h12345678);
        write_row(CSR_OP_SET, `CSR_ADDR_MSCRATCH, 1'b1, 32'h0000000F);
        read_row(`CSR_ADDR_MSCRATCH, 32'h1234567F);
        write_row(CSR_OP_CLEAR, `CSR_ADDR_MSCRATCH, 1'b0, 32'h00000670);
        read_row(`CSR_ADDR_MSCRATCH, 32'h1234500F);
        write_row(CSR_OP_SET, `CSR_ADDR_MSCRATCH, 1'b0, 32'hA0000000);
        read_row(`CSR_ADDR_MSCRATCH, 32'hB234500F);
        write_row(CSR_OP_CLEAR, `CSR_ADDR_MSCRATCH, 1'b1, 32'h0000000C);
        read_row(`CSR_ADDR_MSCRATCH, 32'hB2345003);
        masked_read_row(`CSR_ADDR_MSCRATCH);
        read_row(12'h7C0, 32'h0);
        read_row(12'hF14, 32'h0);

        // Cycle counter load and carry into the high half
        model_row(`CSR_ADDR_MCYCLE);
        model_row(`CSR_ADDR_CYCLE);
        model_row(`CSR_ADDR_MCYCLEH);
        write_row(CSR_OP_WRITE, `CSR_ADDR_MCYCLE, 1'b0, 32'h00001000);
        read_row(`CSR_ADDR_MCYCLE, 32'h00001000);
        model_row(`CSR_ADDR_CYCLE);
        write_row(CSR_OP_WRITE, `CSR_ADDR_MCYCLE, 1'b0, 32'hFFFFFFFF);
        model_row(`CSR_ADDR_MCYCLE);
        model_row(`CSR_ADDR_MCYCLEH);
        read_row(`CSR_ADDR_CYCLEH, 32'h00000001);

        // Retired instructions
        model_row(`CSR_ADDR_MINSTRET);
        retire_row();
        retire_row();
        model_row(`CSR_ADDR_INSTRET);
        retire_row();
        model_row(`CSR_ADDR_MINSTRETH);
        read_row(`CSR_ADDR_INSTRET, 32'd3);

        // Synchronous traps
        write_row(CSR_OP_WRITE, `CSR_ADDR_MTVEC, 1'b1, 32'h00000100);
        read_row(`CSR_ADDR_MTVEC, 32'h00000100);
        trap_row(FLAG_ILLEGAL_CSR, 32'h00000440, 32'h00C0FFEE, 32'h00000100);
        read_row(`CSR_ADDR_MCAUSE, `CAUSE_ILLEGAL_CSR);
        trap_row(FLAG_ILLEGAL_CSR | FLAG_BREAKPOINT, 32'h00000444, 32'hDEAD0011,
                 32'h00000100);
        read_row(`CSR_ADDR_MCAUSE, `CAUSE_BREAKPOINT);
        read_row(`CSR_ADDR_MEPC, 32'h00000444);
        read_row(`CSR_ADDR_MTVAL, 32'hDEAD0011);
        trap_row(FLAG_EXTERNAL, 32'h00000500, 32'h0, 32'h00000100);
        read_row(`CSR_ADDR_MCAUSE, `CAUSE_BREAKPOINT);
        read_row(`CSR_ADDR_MEPC, 32'h00000444);

        // Timer interrupt
        write_row(CSR_OP_WRITE, `CSR_ADDR_CUSTOM_MTIMECMP, 1'b0, 32'd200);
        write_row(CSR_OP_SET, `CSR_ADDR_MSTATUS, 1'b1, 32'h00000008);
        write_row(CSR_OP_SET, `CSR_ADDR_MIE, 1'b0, 32'h00000080);
        read_row(`CSR_ADDR_CUSTOM_MTIMECMP, 32'd200);
        model_row(`CSR_ADDR_CUSTOM_MTIME);
        irq_row(32'd200);
        read_row(`CSR_ADDR_MIP, 32'h00000080);
        trap_row(FLAG_TIMER_TAKEN, 32'h00000A0C, 32'h0, 32'h00000100);
        read_row(`CSR_ADDR_MCAUSE, 32'h80000007);
        read_row(`CSR_ADDR_MIE, 32'h00000808);
        read_row(`CSR_ADDR_MSTATUS, 32'h00000080);
        read_row(`CSR_ADDR_MEPC, 32'h00000A0C);
        write_row(CSR_OP_WRITE, `CSR_ADDR_CUSTOM_MTIMECMP, 1'b0, 32'h0);

        // Return from the handler
        mret_row(32'h00000A0C);
        read_row(`CSR_ADDR_MIP, 32'h0);
        read_row(`CSR_ADDR_MIE, 32'h00000888);
        read_row(`CSR_ADDR_MSTATUS, 32'h00000008);
    endtask

    // ==============================
    // Drive and check
    // ==============================
    task automatic drive_row(input row_t r);
        logic is_trap;
        is_trap      = (r.act == ACT_TRAP);
        csr_wren     = (r.op != CSR_OP_NONE);
        csr_rden     = r.rden;
        csr_op       = r.op;
        csr_addr     = r.addr;
        csr_imm_bit  = r.imm;
        // Unselected source carries the inverse so a wrong select shows up
        csr_imm      = r.imm ? r.data : ~r.data;
        csr_wdata    = r.imm ? ~r.data : r.data;
        inst_retired = (r.act == ACT_RETIRE);
        mret         = (r.act == ACT_MRET);
        {timer_interrupt_taken, external_interrupt, breakpoint,
         illegal_csr_access, misaligned_access, illegal_instruction} = is_trap ? r.flags : 6'b0;
        trap_pc    = is_trap ? r.data : '0;
        trap_mtval = is_trap ? r.mtval : '0;
    endtask

    task automatic check_row(input int idx, input row_t r);
        csr_word_t expected;
        expected = (r.chk == CHK_MODEL) ? model_read(r.addr) : r.exp;
        if (r.chk != CHK_NONE && read_data !== expected) begin
            $display("MISMATCH row %0d read_data: got %h, expected %h",
                     idx, read_data, expected);
            errors++;
        end
        if (jump_en !== r.exp_jump) begin
            $display("MISMATCH row %0d jump_en: got %h, expected %h", idx, jump_en, r.exp_jump);
            errors++;
        end
        if (r.exp_jump && jump_addr !== r.exp_addr) begin
            $display("MISMATCH row %0d jump_addr: got %h, expected %h",
                     idx, jump_addr, r.exp_addr);
            errors++;
        end
        if (return_en !== r.exp_ret) begin
            $display("MISMATCH row %0d return_en: got %h, expected %h",
                     idx, return_en, r.exp_ret);
            errors++;
        end
        if (r.exp_ret && return_addr !== r.exp_addr) begin
            $display("MISMATCH row %0d return_addr: got %h, expected %h",
                     idx, return_addr, r.exp_addr);
            errors++;
        end
        // Interrupt request drops while the core takes it
        if (r.flags[5] && timer_irq_en !== 1'b0) begin
            $display("MISMATCH row %0d timer_irq_en: got %h, expected 0", idx, timer_irq_en);
            errors++;
        end
    endtask

    // Idle cycles reading mtime until the request rises
    task automatic wait_for_irq(input int idx, input csr_word_t rise_time);
        row_t probe;
        int   cycles;
        logic seen;
        probe      = idle_row();
        probe.rden = 1'b1;
        probe.addr = `CSR_ADDR_CUSTOM_MTIME;
        cycles     = 0;
        seen       = 1'b0;
        while (!seen && cycles < IRQ_TIMEOUT) begin
            @(negedge clk);
            drive_row(probe);
            #5;
            seen = timer_irq_en;
            cycles++;
        end
        if (!seen) begin
            $display("Timeout at row %0d: timer_irq_en did not rise within %0d cycles",
                     idx, IRQ_TIMEOUT);
            errors++;
        end else if (read_data !== rise_time) begin
            $display("MISMATCH row %0d mtime at timer_irq_en rise: got %h, expected %h",
                     idx, read_data, rise_time);
            errors++;
        end
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        errors    = 0;
        rows_done = 0;
        drive_row(idle_row());
        build_table();
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        foreach (rows[i]) begin
            if (rows[i].act == ACT_WAIT_IRQ) begin
                wait_for_irq(i, rows[i].data);
            end else begin
                @(negedge clk);
                drive_row(rows[i]);
                #5;
                check_row(i, rows[i]);
            end
            rows_done++;
        end

        @(negedge clk);
        drive_row(idle_row());
        $display("Rows applied: %0d, errors: %0d", rows_done, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
